// ==== battleshipPkg.sv ====
// game-side definitions for the battleship console: board, tiles, port map, bridge structs
`default_nettype none

package battleshipPkg;

    ////////////////////
    // board geometry
    localparam int gridSize  = 10;                    // tiles per side
    localparam int tileCount = gridSize * gridSize;   // 100 tiles per board

    typedef logic [6:0] tileAddrT;                    // row * 10 + column

    typedef enum logic [1:0] {
        tileEmpty = 2'd0,                             // open water
        tileShip  = 2'd1,
        tileHit   = 2'd2,
        tileMiss  = 2'd3
    } tileStateT;

    ////////////////////
    // processor port map
    typedef enum logic [7:0] {
        cursorPort    = 8'h01,                        // tile under the cursor
        shipPort      = 8'h02,                        // bit 4 orientation, bits 2:0 length
        usAddrPort    = 8'h03,
        usDataPort    = 8'h04,                        // read or write the us tile
        themAddrPort  = 8'h05,
        themDataPort  = 8'h06,                        // read or write the them tile
        switchPort    = 8'h07,
        ledPort       = 8'h08,
        irqStatusPort = 8'h09                         // bit 0 is the interrupt level
    } portIdT;

    typedef enum logic {
        horizontal = 1'b0,                            // ship grows to the right
        vertical   = 1'b1                             // ship grows downward
    } orientT;

    typedef struct packed {
        orientT     orient;
        logic [2:0] length;                           // 1 to 5 tiles
    } shipInfoT;

    // one write into a tile memory
    typedef struct packed {
        logic      en;
        tileAddrT  addr;
        tileStateT data;
    } ramWriteT;

    localparam int tickPeriodDefault = 18_000_000;   // about 0.18 s at 100 MHz

endpackage

`default_nettype wire

// ==== videoPkg.sv ====
// video-side definitions: 640x480 display timing, pixel position and screen colors
`default_nettype none

package videoPkg;

    ////////////////////
    // horizontal timing in pixels
    localparam int hVisible = 640;
    localparam int hFront   = 16;
    localparam int hSync    = 96;
    localparam int hBack    = 48;
    localparam int hTotal   = hVisible + hFront + hSync + hBack;   // 800

    // vertical timing in lines
    localparam int vVisible = 480;
    localparam int vFront   = 10;
    localparam int vSync    = 2;
    localparam int vBack    = 33;
    localparam int vTotal   = vVisible + vFront + vSync + vBack;   // 525

    localparam int pixelDiv = 4;              // clk cycles per pixel

    ////////////////////
    // board layout on screen
    localparam int tilePixels = 32;
    localparam int gridUsX0   = 32;           // left board, our ships
    localparam int gridThemX0 = 352;          // right board, our guesses
    localparam int gridY0     = 96;           // both boards share the top edge

    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
        logic       videoOn;
    } pixelPosT;

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } colorT;

    localparam colorT colorEmpty = '{red: 4'h1, green: 4'h5, blue: 4'hc};   // water
    localparam colorT colorShip  = '{red: 4'h8, green: 4'h8, blue: 4'h8};
    localparam colorT colorHit   = '{red: 4'hf, green: 4'h0, blue: 4'h0};
    localparam colorT colorMiss  = '{red: 4'hf, green: 4'hf, blue: 4'hf};
    localparam colorT colorGhost = '{red: 4'hf, green: 4'hf, blue: 4'h0};   // ship being placed
    localparam colorT colorBlack = '{red: 4'h0, green: 4'h0, blue: 4'h0};

endpackage

`default_nettype wire

// ==== tileRam.sv ====
// dual-port tile memory for one 10x10 board, cleared by a sweep after reset
`default_nettype none

module tileRam (
    input  wire logic                     clk,
    input  wire logic                     rstN,
    input  wire battleshipPkg::ramWriteT  wrA,
    input  wire battleshipPkg::tileAddrT  addrA,
    output battleshipPkg::tileStateT      dataA,
    input  wire battleshipPkg::tileAddrT  addrB,
    output battleshipPkg::tileStateT      dataB
);
    import battleshipPkg::*;

    tileStateT mem [tileCount];
    tileAddrT  sweepAddr;                     // next tile to clear
    logic      sweeping;

    // sweep walks 0..99 once after reset
    always_ff @(posedge clk) begin
        if (!rstN) begin
            sweeping  <= 1'b1;
            sweepAddr <= '0;
        end else if (sweeping) begin
            sweepAddr <= sweepAddr + 1'b1;
            if (sweepAddr == tileAddrT'(tileCount - 1))
                sweeping <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (sweeping)
            mem[sweepAddr] <= tileEmpty;       // sweep owns the write port
        else if (wrA.en)
            mem[wrA.addr] <= wrA.data;
        dataA <= sweeping ? tileEmpty : mem[addrA];   // board reads empty until clear
        dataB <= sweeping ? tileEmpty : mem[addrB];
    end

endmodule

`default_nettype wire

// ==== portBridge.sv ====
// processor port bridge: board registers, tile memory access and the periodic tick interrupt
`default_nettype none

module portBridge #(
    parameter int tickPeriod = battleshipPkg::tickPeriodDefault
) (
    input  wire logic                      clk,
    input  wire logic                      rstN,
    input  wire battleshipPkg::portIdT     portId,
    input  wire logic [7:0]                outPort,
    input  wire logic                      writeStrobe,
    input  wire logic                      readStrobe,
    output logic [7:0]                     inPort,
    output logic                           interrupt,
    input  wire logic                      interruptAck,
    input  wire logic [15:0]               switches,
    output logic [15:0]                    leds,
    output battleshipPkg::ramWriteT        usWr,
    output battleshipPkg::ramWriteT        themWr,
    output battleshipPkg::tileAddrT        usRdAddr,
    output battleshipPkg::tileAddrT        themRdAddr,
    input  wire battleshipPkg::tileStateT  usRdData,
    input  wire battleshipPkg::tileStateT  themRdData,
    output battleshipPkg::tileAddrT        cursor,
    output battleshipPkg::shipInfoT        shipInfo
);
    import battleshipPkg::*;

    localparam int tickW = $clog2(tickPeriod);

    tileAddrT         usAddr;                 // last address written to usAddrPort
    tileAddrT         themAddr;
    logic [7:0]       ledLow;
    portIdT           portIdQ;                // select lined up with port A read data
    logic             readQ;                  // strobe lined up with portIdQ
    logic [tickW-1:0] tickCount;
    logic             tickWrap;

    ////////////////////
    // port writes
    always_ff @(posedge clk) begin
        if (!rstN) begin
            usAddr   <= '0;
            themAddr <= '0;
            cursor   <= '0;
            shipInfo <= '{orient: horizontal, length: 3'd1};
            ledLow   <= '0;
        end else if (writeStrobe) begin
            case (portId)
                cursorPort:   cursor   <= outPort[6:0];
                shipPort:     shipInfo <= '{orient: orientT'(outPort[4]), length: outPort[2:0]};
                usAddrPort:   usAddr   <= outPort[6:0];
                themAddrPort: themAddr <= outPort[6:0];
                ledPort:      ledLow   <= outPort;
                default:      ;
            endcase
        end
    end

    // data port writes go straight to port A, landing on the strobe edge
    always_comb begin
        usWr.en     = writeStrobe && (portId == usDataPort);
        usWr.addr   = usAddr;
        usWr.data   = tileStateT'(outPort[1:0]);
        themWr.en   = writeStrobe && (portId == themDataPort);
        themWr.addr = themAddr;
        themWr.data = tileStateT'(outPort[1:0]);
    end

    assign usRdAddr   = usAddr;
    assign themRdAddr = themAddr;
    assign leds       = {1'b0, cursor, ledLow};   // high byte follows the cursor

    ////////////////////
    // read mux, two stages: select, then the byte
    always_ff @(posedge clk) begin
        portIdQ <= portId;
        readQ   <= readStrobe;
        case (portIdQ)
            usDataPort:    inPort <= {6'b0, usRdData};
            themDataPort:  inPort <= {6'b0, themRdData};
            switchPort:    inPort <= switches[7:0];
            irqStatusPort: inPort <= {7'b0, interrupt};   // plain status, no clear
            default:       inPort <= readQ ? 8'h00 : inPort;   // idle bus holds the last byte
        endcase
    end

    ////////////////////
    // tick counter and interrupt flag
    always_ff @(posedge clk) begin
        if (!rstN) begin
            tickCount <= '0;
            tickWrap  <= 1'b0;
            interrupt <= 1'b0;
        end else begin
            tickWrap <= (tickCount == tickW'(tickPeriod - 1));
            if (tickCount == tickW'(tickPeriod - 1))
                tickCount <= '0;
            else
                tickCount <= tickCount + 1'b1;
            // a fresh tick wins over an ack in the same cycle
            if (tickWrap)
                interrupt <= 1'b1;
            else if (interruptAck)
                interrupt <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== displayTiming.sv ====
// 640x480 display timing: pixel enable, frame counters, syncs and video-on
`default_nettype none

module displayTiming (
    input  wire logic         clk,
    input  wire logic         rstN,
    output videoPkg::pixelPosT pixel,
    output logic              hSyncN,
    output logic              vSyncN
);
    import videoPkg::*;

    localparam int divW = $clog2(pixelDiv);

    logic [divW-1:0] divCount;
    logic            pixelEn;                 // one clk in every four
    logic [9:0]      hCount;
    logic [9:0]      vCount;

    assign pixelEn = (divCount == divW'(pixelDiv - 1));

    always_ff @(posedge clk) begin
        if (!rstN || pixelEn)
            divCount <= '0;
        else
            divCount <= divCount + 1'b1;
    end

    ////////////////////
    // frame counters, 800 x 525
    always_ff @(posedge clk) begin
        if (!rstN) begin
            hCount <= '0;
            vCount <= '0;
        end else if (pixelEn) begin
            if (hCount == 10'(hTotal - 1)) begin
                hCount <= '0;                 // end of line
                if (vCount == 10'(vTotal - 1))
                    vCount <= '0;
                else
                    vCount <= vCount + 1'b1;
            end else begin
                hCount <= hCount + 1'b1;
            end
        end
    end

    // sync pulses sit after the front porch
    assign hSyncN = !((hCount >= 10'(hVisible + hFront)) &&
                      (hCount < 10'(hVisible + hFront + hSync)));
    assign vSyncN = !((vCount >= 10'(vVisible + vFront)) &&
                      (vCount < 10'(vVisible + vFront + vSync)));

    assign pixel.x       = hCount;
    assign pixel.y       = vCount;
    assign pixel.videoOn = (hCount < 10'(hVisible)) && (vCount < 10'(vVisible));

endmodule

`default_nettype wire

// ==== ghostShip.sv ====
// ghost ship overlay: flags pixels on the ship being placed at the cursor
`default_nettype none

module ghostShip (
    input  wire videoPkg::pixelPosT       pixel,
    input  wire battleshipPkg::tileAddrT  cursor,
    input  wire battleshipPkg::shipInfoT  shipInfo,
    output logic                          onGhost
);
    import battleshipPkg::*;
    import videoPkg::*;

    localparam int gridSpan = gridSize * tilePixels;   // board width in pixels

    logic [3:0] curRow;
    logic [3:0] curCol;
    logic [3:0] tileRow;                      // tile under the pixel, us board
    logic [3:0] tileCol;
    logic [4:0] rowEnd;                       // one past the last ship tile
    logic [4:0] colEnd;
    logic [9:0] xRel;
    logic [9:0] yRel;
    logic       inGrid;

    assign curRow  = 4'(cursor / gridSize);
    assign curCol  = 4'(cursor % gridSize);
    assign xRel    = pixel.x - 10'(gridUsX0);
    assign yRel    = pixel.y - 10'(gridY0);
    assign tileRow = 4'(yRel / tilePixels);
    assign tileCol = 4'(xRel / tilePixels);
    assign rowEnd  = {1'b0, curRow} + {2'b0, shipInfo.length};
    assign colEnd  = {1'b0, curCol} + {2'b0, shipInfo.length};

    assign inGrid = (pixel.x >= 10'(gridUsX0)) && (pixel.x < 10'(gridUsX0 + gridSpan)) &&
                    (pixel.y >= 10'(gridY0)) && (pixel.y < 10'(gridY0 + gridSpan));

    // tiles past column or row 9 never match, so the ship clips at the edge
    always_comb begin
        onGhost = 1'b0;
        if (inGrid) begin
            if (shipInfo.orient == horizontal)
                onGhost = (tileRow == curRow) && (tileCol >= curCol) &&
                          ({1'b0, tileCol} < colEnd);
            else
                onGhost = (tileCol == curCol) && (tileRow >= curRow) &&
                          ({1'b0, tileRow} < rowEnd);
        end
    end

endmodule

`default_nettype wire

// ==== tileRenderer.sv ====
// tile renderer: reads both boards on port B and builds the color and syncs, 2 clk late
`default_nettype none

module tileRenderer (
    input  wire logic                     clk,
    input  wire logic                     rstN,
    input  wire videoPkg::pixelPosT       pixel,
    input  wire logic                     hSyncIn,
    input  wire logic                     vSyncIn,
    input  wire logic                     onGhost,
    output battleshipPkg::tileAddrT       usAddr,
    output battleshipPkg::tileAddrT       themAddr,
    input  wire battleshipPkg::tileStateT usTile,
    input  wire battleshipPkg::tileStateT themTile,
    output videoPkg::colorT               color,
    output logic                          hSyncN,
    output logic                          vSyncN
);
    import battleshipPkg::*;
    import videoPkg::*;

    localparam int gridSpan = gridSize * tilePixels;

    // what travels beside the port B read
    typedef struct packed {
        logic videoOn;
        logic inUs;
        logic inThem;
        logic ghost;
        logic hSyncN;
        logic vSyncN;
    } stageT;

    logic [9:0] yRel;
    logic [9:0] xUsRel;
    logic [9:0] xThemRel;
    logic [3:0] tileRow;
    logic [3:0] usCol;
    logic [3:0] themCol;
    logic       inRows;                       // pixel within the board rows
    stageT      s1;

    function automatic colorT tileColor(tileStateT state);
        case (state)
            tileShip: return colorShip;
            tileHit:  return colorHit;
            tileMiss: return colorMiss;
            default:  return colorEmpty;
        endcase
    endfunction

    ////////////////////
    // stage 0, pixel to tile address
    assign yRel     = pixel.y - 10'(gridY0);
    assign xUsRel   = pixel.x - 10'(gridUsX0);
    assign xThemRel = pixel.x - 10'(gridThemX0);
    assign tileRow  = 4'(yRel / tilePixels);
    assign usCol    = 4'(xUsRel / tilePixels);
    assign themCol  = 4'(xThemRel / tilePixels);
    assign inRows   = (pixel.y >= 10'(gridY0)) && (pixel.y < 10'(gridY0 + gridSpan));
    assign usAddr   = tileAddrT'(tileRow * gridSize + usCol);
    assign themAddr = tileAddrT'(tileRow * gridSize + themCol);

    // stage 1, tiles come back from port B
    always_ff @(posedge clk) begin
        if (!rstN) begin
            s1 <= '{videoOn: 1'b0, inUs: 1'b0, inThem: 1'b0, ghost: 1'b0,
                    hSyncN: 1'b1, vSyncN: 1'b1};
        end else begin
            s1.videoOn <= pixel.videoOn;
            s1.inUs    <= inRows && (pixel.x >= 10'(gridUsX0)) &&
                          (pixel.x < 10'(gridUsX0 + gridSpan));
            s1.inThem  <= inRows && (pixel.x >= 10'(gridThemX0)) &&
                          (pixel.x < 10'(gridThemX0 + gridSpan));
            s1.ghost   <= onGhost;
            s1.hSyncN  <= hSyncIn;
            s1.vSyncN  <= vSyncIn;
        end
    end

    // stage 2, pick the color
    always_ff @(posedge clk) begin
        if (!rstN) begin
            color  <= colorBlack;
            hSyncN <= 1'b1;
            vSyncN <= 1'b1;
        end else begin
            hSyncN <= s1.hSyncN;
            vSyncN <= s1.vSyncN;
            if (!s1.videoOn)
                color <= colorBlack;          // blanking
            else if (s1.inUs && s1.ghost)
                color <= colorGhost;          // ghost covers the us board
            else if (s1.inUs)
                color <= tileColor(usTile);
            else if (s1.inThem)
                color <= tileColor(themTile);
            else
                color <= colorBlack;
        end
    end

endmodule

`default_nettype wire

// ==== battleshipTop.sv ====
// battleship console top: port bridge, us and them tile boards, display chain
`default_nettype none

module battleshipTop #(
    parameter int tickPeriod = battleshipPkg::tickPeriodDefault
) (
    input  wire logic                   clk,
    input  wire logic                   rstN,
    input  wire battleshipPkg::portIdT  portId,
    input  wire logic [7:0]             outPort,
    input  wire logic                   writeStrobe,
    input  wire logic                   readStrobe,
    output wire logic [7:0]             inPort,
    output wire logic                   interrupt,
    input  wire logic                   interruptAck,
    input  wire logic [15:0]            switches,
    output wire logic [15:0]            leds,
    output wire videoPkg::colorT        vgaColor,
    output wire logic                   hSyncN,
    output wire logic                   vSyncN
);
    import battleshipPkg::*;
    import videoPkg::*;

    ramWriteT  usWr;
    ramWriteT  themWr;
    tileAddrT  usRdAddr;                      // port A, bridge side
    tileAddrT  themRdAddr;
    tileStateT usRdData;
    tileStateT themRdData;
    tileAddrT  usVidAddr;                     // port B, video side
    tileAddrT  themVidAddr;
    tileStateT usVidData;
    tileStateT themVidData;
    tileAddrT  cursor;
    shipInfoT  shipInfo;
    pixelPosT  pixel;
    logic      rawHSyncN;                     // syncs before the renderer delay
    logic      rawVSyncN;
    logic      onGhost;

    portBridge #(.tickPeriod(tickPeriod)) i_portBridge (
        .clk(clk), .rstN(rstN),
        .portId(portId), .outPort(outPort), .writeStrobe(writeStrobe),
        .readStrobe(readStrobe), .inPort(inPort),
        .interrupt(interrupt), .interruptAck(interruptAck),
        .switches(switches), .leds(leds),
        .usWr(usWr), .themWr(themWr),
        .usRdAddr(usRdAddr), .themRdAddr(themRdAddr),
        .usRdData(usRdData), .themRdData(themRdData),
        .cursor(cursor), .shipInfo(shipInfo)
    );

    tileRam usRam (
        .clk(clk), .rstN(rstN),
        .wrA(usWr), .addrA(usRdAddr), .dataA(usRdData),
        .addrB(usVidAddr), .dataB(usVidData)
    );

    tileRam themRam (
        .clk(clk), .rstN(rstN),
        .wrA(themWr), .addrA(themRdAddr), .dataA(themRdData),
        .addrB(themVidAddr), .dataB(themVidData)
    );

    ////////////////////
    // video chain
    displayTiming i_displayTiming (
        .clk(clk), .rstN(rstN),
        .pixel(pixel), .hSyncN(rawHSyncN), .vSyncN(rawVSyncN)
    );

    ghostShip i_ghostShip (
        .pixel(pixel), .cursor(cursor), .shipInfo(shipInfo), .onGhost(onGhost)
    );

    tileRenderer i_tileRenderer (
        .clk(clk), .rstN(rstN),
        .pixel(pixel), .hSyncIn(rawHSyncN), .vSyncIn(rawVSyncN), .onGhost(onGhost),
        .usAddr(usVidAddr), .themAddr(themVidAddr),
        .usTile(usVidData), .themTile(themVidData),
        .color(vgaColor), .hSyncN(hSyncN), .vSyncN(vSyncN)
    );

endmodule

`default_nettype wire

// ==== tbBattleship.sv ====
// battleship console testbench: plays the processor on the port bus and samples the screen
`default_nettype none

module tbBattleship;
    import battleshipPkg::*;
    import videoPkg::*;

    localparam int    tickPeriod  = 500;                          // short tick for simulation
    localparam int    frameCycles = hTotal * vTotal * pixelDiv;
    localparam string testFile    = "battleshipTests.txt";

    logic        clk;
    logic        rstN;
    portIdT      portId;
    logic [7:0]  outPort;
    logic        writeStrobe;
    logic        readStrobe;
    logic [7:0]  inPort;
    logic        interrupt;
    logic        interruptAck;
    logic [15:0] switches;
    logic [15:0] leds;
    colorT       vgaColor;
    logic        hSyncN;
    logic        vSyncN;

    // screen position as seen at the DUT outputs
    logic [9:0]  trackX = '0;
    logic [9:0]  trackY = '0;
    logic [1:0]  phase = '0;                  // clk within the pixel
    logic        locked = 1'b0;               // set at the first vsync
    logic        prevH = 1'b1;
    logic        prevV = 1'b1;
    int          cycleCount = 0;
    int          cycleLimit = 0;              // 0 until the test file is counted

    battleshipTop #(.tickPeriod(tickPeriod)) i_battleshipTop (
        .clk(clk), .rstN(rstN),
        .portId(portId), .outPort(outPort), .writeStrobe(writeStrobe),
        .readStrobe(readStrobe), .inPort(inPort),
        .interrupt(interrupt), .interruptAck(interruptAck),
        .switches(switches), .leds(leds),
        .vgaColor(vgaColor), .hSyncN(hSyncN), .vSyncN(vSyncN)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    ////////////////////
    // compare tasks
    task automatic checkByte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp)
            abortRun($sformatf("error at %0t: %s = %h, expected %h", $time, name, got, exp));
    endtask

    task automatic checkTile(input string name, input tileStateT got, input tileStateT exp);
        if (got !== exp)
            abortRun($sformatf("error at %0t: %s = %s, expected %s", $time, name,
                               got.name(), exp.name()));
    endtask

    task automatic checkColor(input string name, input colorT got, input colorT exp);
        if (got !== exp)
            abortRun($sformatf("error at %0t: %s = %h, expected %h", $time, name, got, exp));
    endtask

    task automatic checkLevel(input string name, input logic got, input logic exp);
        if (got !== exp)
            abortRun($sformatf("error at %0t: %s = %b, expected %b", $time, name, got, exp));
    endtask

    ////////////////////
    // processor side of the port bus
    task automatic writePort(input portIdT p, input logic [7:0] d);
        @(posedge clk);
        portId      <= p;
        outPort     <= d;
        writeStrobe <= 1'b1;
        @(posedge clk);                       // write lands on this edge
        writeStrobe <= 1'b0;
    endtask

    task automatic readPort(input portIdT p, output logic [7:0] value);
        @(posedge clk);
        portId     <= p;
        readStrobe <= 1'b1;
        repeat (2) @(posedge clk);            // select, then the byte
        @(negedge clk);
        value = inPort;
        @(posedge clk);
        readStrobe <= 1'b0;
    endtask

    task automatic readTile(input logic them, input tileAddrT addr, input tileStateT exp);
        logic [7:0] value;
        if (them) begin
            writePort(themAddrPort, {1'b0, addr});
            readPort(themDataPort, value);
            checkTile($sformatf("them tile %0d", addr), tileStateT'(value[1:0]), exp);
        end else begin
            writePort(usAddrPort, {1'b0, addr});
            readPort(usDataPort, value);
            checkTile($sformatf("us tile %0d", addr), tileStateT'(value[1:0]), exp);
        end
    endtask

    task automatic waitInterrupt(input int minWait);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!interrupt && waited <= tickPeriod + 2) begin
            waited++;
            @(negedge clk);
        end
        if (!interrupt)
            abortRun("interrupt did not rise within one tick period");
        if (waited < minWait)
            abortRun($sformatf("interrupt rose after %0d cycles, sooner than %0d",
                               waited, minWait));
    endtask

    task automatic ackInterrupt();
        @(posedge clk);
        interruptAck <= 1'b1;
        @(posedge clk);
        interruptAck <= 1'b0;
        @(negedge clk);
        checkLevel("interrupt", interrupt, 1'b0);
    endtask

    // waits for the middle of pixel x,y in the tracked raster
    task automatic samplePixel(input logic [9:0] x, input logic [9:0] y, input colorT exp);
        @(negedge clk);
        while (!(locked && trackX == x && trackY == y && phase == 2'd1))
            @(negedge clk);
        checkColor($sformatf("vgaColor at %0d,%0d", x, y), vgaColor, exp);
    endtask

    task automatic skipLine(input int fd);
        int ch;
        ch = $fgetc(fd);
        while (ch != 10 && ch != -1)
            ch = $fgetc(fd);
    endtask

    ////////////////////
    // raster tracker, locks on the vsync edge, hsync must agree
    always @(negedge clk) begin
        prevH <= hSyncN;
        prevV <= vSyncN;
        if (prevV && !vSyncN) begin
            if (locked && !(trackY == 10'(vVisible + vFront - 1) &&
                            trackX == 10'(hTotal - 1) && phase == 2'd3))
                abortRun("vertical sync came at the wrong place in the frame");
            trackX <= '0;                     // vsync output falls at x 0, line 490
            trackY <= 10'(vVisible + vFront);
            phase  <= '0;
            locked <= 1'b1;
        end else if (locked) begin
            if (prevH && !hSyncN && !(trackX == 10'(hVisible + hFront - 1) && phase == 2'd3))
                abortRun("horizontal sync came at the wrong place in the line");
            phase <= phase + 2'd1;
            if (phase == 2'd3) begin
                if (trackX == 10'(hTotal - 1)) begin
                    trackX <= '0;
                    trackY <= (trackY == 10'(vTotal - 1)) ? '0 : trackY + 10'd1;
                end else begin
                    trackX <= trackX + 10'd1;
                end
            end
        end
    end

    // run limit
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit != 0 && cycleCount >= cycleLimit)
            abortRun($sformatf("the tests did not finish within %0d cycles", cycleLimit));
    end

    ////////////////////
    // main sequence
    initial begin
        int         fd;
        int         n;
        int         lineCount;
        logic [7:0] op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [7:0] value;
        rstN         <= 1'b0;
        portId       <= cursorPort;
        outPort      <= '0;
        writeStrobe  <= 1'b0;
        readStrobe   <= 1'b0;
        interruptAck <= 1'b0;
        switches     <= '0;

        // first pass only counts operations for the run limit
        fd = $fopen(testFile, "r");
        if (fd == 0)
            abortRun("cannot open the test file battleshipTests.txt");
        lineCount = 0;
        while ($fscanf(fd, " %c", op) == 1) begin
            if (op != "#")
                lineCount++;
            skipLine(fd);
        end
        $fclose(fd);
        cycleLimit = 3 * frameCycles + 1000 * lineCount;

        repeat (16) @(posedge clk);
        rstN <= 1'b1;

        fd = $fopen(testFile, "r");
        while ($fscanf(fd, " %c", op) == 1) begin
            if (op == "#") begin
                skipLine(fd);
            end else begin
                n = $fscanf(fd, "%h %h %h", a, b, c);
                if (n != 3)
                    abortRun($sformatf("test line for operation %c is incomplete", op));
                case (op)
                    "w": writePort(portIdT'(a[7:0]), b[7:0]);
                    "r": begin
                        readPort(portIdT'(a[7:0]), value);
                        checkByte("inPort", value, b[7:0]);
                    end
                    "u": readTile(1'b0, a[6:0], tileStateT'(b[1:0]));
                    "t": readTile(1'b1, a[6:0], tileStateT'(b[1:0]));
                    "l": begin
                        @(negedge clk);
                        checkByte("leds[7:0]", leds[7:0], a[7:0]);
                        checkByte("leds[15:8]", leds[15:8], b[7:0]);   // cursor
                    end
                    "s": begin
                        @(posedge clk);
                        switches <= a[15:0];
                    end
                    "v": begin
                        @(negedge clk);
                        checkLevel("interrupt", interrupt, a[0]);
                    end
                    "i": waitInterrupt(a);
                    "a": ackInterrupt();
                    "c": repeat (a) @(posedge clk);
                    "p": samplePixel(a[9:0], b[9:0], colorT'(c[11:0]));
                    default: abortRun($sformatf("unknown operation %c in the test file", op));
                endcase
            end
        end
        $fclose(fd);

        repeat (4) @(posedge clk);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== battleshipTop.f ====
battleshipPkg.sv
videoPkg.sv
tileRam.sv
portBridge.sv
displayTiming.sv
ghostShip.sv
tileRenderer.sv
battleshipTop.sv
tbBattleship.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the battleship console testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -f battleshipTop.f --top-module tbBattleship -o simBattleship

# tee keeps the run going to the log search even when the simulation stops early
./obj_dir/simBattleship 2>&1 | tee sim.log

if grep -q "Simulation failed" sim.log; then
    echo "test run reported a failure, see sim.log"
    exit 1
fi
echo "test run finished without failures"

// ==== battleshipTests.txt ====
# op a b c, all numbers hex: w port data, r port byte, u|t tile state, l ledLow ledHigh,
# s switches, v irqLevel, i minCycles, a (ack), c cycles, p x y color
v 0 0 0
l 0 0 0
c 70 0 0
u 00 0 0
u 63 0 0
t 00 0 0
t 63 0 0
w 03 0c 0
w 04 01 0
u 0c 1 0
t 0c 0 0
r 04 01 0
w 01 17 0
w 08 a5 0
l a5 17 0
s 5a3c 0 0
r 07 3c 0
w 03 35 0
w 04 02 0
w 03 50 0
w 04 03 0
w 03 21 0
w 04 01 0
w 05 07 0
w 06 03 0
w 05 41 0
w 06 02 0
w 02 13 0
i 0 0 0
r 09 01 0
a 0 0 0
i 1e0 0 0
p 2bc 00a 000
p 250 070 fff
p 010 090 000
p 070 090 888
p 090 0b0 ff0
p 0b0 0b0 15c
p 090 0d0 ff0
p 090 0f0 ff0
p 090 110 f00
p 210 130 f00
w 01 4e 0
w 02 05 0
p 110 150 15c
p 130 150 ff0
p 150 150 ff0
p 030 170 fff
p 050 170 15c
p 090 1ae 000
